// ==== hw/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

    // Datapath widths
    localparam int XLEN        = 32;
    localparam int PRF_ID_BITS = 6;
    localparam int ROB_ID_BITS = 5;
    localparam int PADDR_BITS  = 32;

    // Shift amount field of src2
    localparam int SHAMT_BITS  = 5;

    typedef logic [XLEN-1:0]        t_reg_data;
    typedef logic [PRF_ID_BITS-1:0] t_prf_id;
    typedef logic [ROB_ID_BITS-1:0] t_rob_id;
    typedef logic [PADDR_BITS-1:0]  t_paddr;
    typedef logic [SHAMT_BITS-1:0]  t_shamt;

    // Integer micro-ops, the full 4-bit space is used
    typedef enum logic [3:0] {
        U_ADD  = 4'd0,
        U_SUB  = 4'd1,
        U_AND  = 4'd2,
        U_OR   = 4'd3,
        U_XOR  = 4'd4,
        U_SLL  = 4'd5,
        U_SRL  = 4'd6,
        U_SRA  = 4'd7,
        U_SLT  = 4'd8,
        U_SLTU = 4'd9,
        U_BEQ  = 4'd10,
        U_BNE  = 4'd11,
        U_BLT  = 4'd12,
        U_BGE  = 4'd13,
        U_BLTU = 4'd14,
        U_BGEU = 4'd15
    } t_uop;

    // Operand kind for src2 and for the destination
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_REG  = 2'd1,
        OP_IMM  = 2'd2
    } t_optype;

endpackage

`default_nettype wire

// ==== hw/int_prf.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_prf #(
    parameter int NUM_PREGS = 64
) (
    input  logic                clk,
    input  logic                reset,

    input  exe_pkg::t_prf_id    rd_addr1,
    input  exe_pkg::t_prf_id    rd_addr2,
    output exe_pkg::t_reg_data  rd_data1,
    output exe_pkg::t_reg_data  rd_data2,

    input  logic                wr_en,
    input  exe_pkg::t_prf_id    wr_addr,
    input  exe_pkg::t_reg_data  wr_data
);

    exe_pkg::t_reg_data regs [NUM_PREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through so a same-cycle reader sees the new value
    always_comb begin
        if (wr_en && (wr_addr == rd_addr1)) begin
            rd_data1 = wr_data;
        end else begin
            rd_data1 = regs[rd_addr1];
        end

        if (wr_en && (wr_addr == rd_addr2)) begin
            rd_data2 = wr_data;
        end else begin
            rd_data2 = regs[rd_addr2];
        end
    end

    // Writeback from EX1 must target an implemented register
    a_wr_addr_range: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> (int'(wr_addr) < NUM_PREGS)
    ) else $error("int_prf write to pdst %0h beyond %0d entries", wr_addr, NUM_PREGS);

endmodule

`default_nettype wire

// ==== hw/reg_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_read (
    input  logic                clk,
    input  logic                reset,
    input  logic                nuke,

    input  logic                iss_valid,
    input  exe_pkg::t_uop       iss_uop,
    input  exe_pkg::t_prf_id    iss_src1,
    input  exe_pkg::t_prf_id    iss_src2,
    input  exe_pkg::t_optype    iss_src2_type,
    input  exe_pkg::t_reg_data  iss_imm,
    input  exe_pkg::t_prf_id    iss_pdst,
    input  exe_pkg::t_optype    iss_dst_type,
    input  exe_pkg::t_rob_id    iss_robid,
    input  exe_pkg::t_paddr     iss_pc,

    input  exe_pkg::t_reg_data  rd_data1,
    input  exe_pkg::t_reg_data  rd_data2,

    input  logic                wb_en,
    input  exe_pkg::t_prf_id    wb_pdst,
    input  exe_pkg::t_reg_data  wb_data,

    output logic                ex0_valid,
    output exe_pkg::t_uop       ex0_uop,
    output exe_pkg::t_optype    ex0_src2_type,
    output exe_pkg::t_reg_data  ex0_imm,
    output exe_pkg::t_prf_id    ex0_pdst,
    output exe_pkg::t_optype    ex0_dst_type,
    output exe_pkg::t_rob_id    ex0_robid,
    output exe_pkg::t_paddr     ex0_pc,
    output exe_pkg::t_reg_data  ex0_src1_val,
    output exe_pkg::t_reg_data  ex0_src2_reg_val
);

    exe_pkg::t_prf_id   src1_q;
    exe_pkg::t_prf_id   src2_q;
    exe_pkg::t_reg_data rd1_q;
    exe_pkg::t_reg_data rd2_q;

    // A micro-op issued alongside nuke never enters EX0
    always_ff @(posedge clk) begin
        if (reset) begin
            ex0_valid <= 1'b0;
        end else begin
            ex0_valid <= iss_valid & ~nuke;
        end
    end

    always_ff @(posedge clk) begin
        ex0_uop       <= iss_uop;
        ex0_src2_type <= iss_src2_type;
        ex0_imm       <= iss_imm;
        ex0_pdst      <= iss_pdst;
        ex0_dst_type  <= iss_dst_type;
        ex0_robid     <= iss_robid;
        ex0_pc        <= iss_pc;
        src1_q        <= iss_src1;
        src2_q        <= iss_src2;
        rd1_q         <= rd_data1;
        rd2_q         <= rd_data2;
    end

    // EX1 result overrides the stale read for a back-to-back dependent
    always_comb begin
        ex0_src1_val     = (wb_en && (wb_pdst == src1_q)) ? wb_data : rd1_q;
        ex0_src2_reg_val = (wb_en && (wb_pdst == src2_q)) ? wb_data : rd2_q;
    end

endmodule

`default_nettype wire

// ==== hw/int_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  exe_pkg::t_uop       uop,
    input  logic                valid,
    input  exe_pkg::t_reg_data  src1,
    input  exe_pkg::t_reg_data  src2,
    output logic                resvld,
    output exe_pkg::t_reg_data  result
);

    exe_pkg::t_shamt shamt;
    logic            is_alu;

    assign shamt = src2[exe_pkg::SHAMT_BITS-1:0];

    always_comb begin
        is_alu = 1'b1;
        result = '0;
        case (uop)
            exe_pkg::U_ADD:  result = src1 + src2;
            exe_pkg::U_SUB:  result = src1 - src2;
            exe_pkg::U_AND:  result = src1 & src2;
            exe_pkg::U_OR:   result = src1 | src2;
            exe_pkg::U_XOR:  result = src1 ^ src2;
            exe_pkg::U_SLL:  result = src1 << shamt;
            exe_pkg::U_SRL:  result = src1 >> shamt;
            exe_pkg::U_SRA:  result = $signed(src1) >>> shamt;
            exe_pkg::U_SLT: begin
                result = {{(exe_pkg::XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            exe_pkg::U_SLTU: begin
                result = {{(exe_pkg::XLEN-1){1'b0}}, src1 < src2};
            end
            default: begin
                // Branches go to branch_unit
                is_alu = 1'b0;
            end
        endcase
    end

    assign resvld = valid & is_alu;

endmodule

`default_nettype wire

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic                valid,
    input  exe_pkg::t_uop       uop,
    input  exe_pkg::t_reg_data  src1,
    input  exe_pkg::t_reg_data  src2,
    input  exe_pkg::t_paddr     pc,
    input  exe_pkg::t_reg_data  imm,
    input  exe_pkg::t_rob_id    robid,
    output logic                resvld,
    output logic                mispred_valid,
    output exe_pkg::t_rob_id    mispred_robid,
    output exe_pkg::t_paddr     mispred_target
);

    logic is_branch;
    logic taken;
    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (src1 == src2);
    assign lt_s = ($signed(src1) < $signed(src2));
    assign lt_u = (src1 < src2);

    always_comb begin
        is_branch = 1'b1;
        taken     = 1'b0;
        case (uop)
            exe_pkg::U_BEQ:  taken = eq;
            exe_pkg::U_BNE:  taken = ~eq;
            exe_pkg::U_BLT:  taken = lt_s;
            exe_pkg::U_BGE:  taken = ~lt_s;
            exe_pkg::U_BLTU: taken = lt_u;
            exe_pkg::U_BGEU: taken = ~lt_u;
            default:         is_branch = 1'b0;
        endcase
    end

    assign resvld = valid & is_branch;

    // Predicted not taken, so every taken branch redirects
    assign mispred_valid  = valid & is_branch & taken;
    assign mispred_robid  = robid;
    assign mispred_target = pc + imm;

endmodule

`default_nettype wire

// ==== hw/exe.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe (
    input  logic                clk,
    input  logic                reset,
    input  logic                nuke,

    input  logic                ex0_valid,
    input  exe_pkg::t_uop       ex0_uop,
    input  exe_pkg::t_optype    ex0_src2_type,
    input  exe_pkg::t_reg_data  ex0_imm,
    input  exe_pkg::t_prf_id    ex0_pdst,
    input  exe_pkg::t_optype    ex0_dst_type,
    input  exe_pkg::t_rob_id    ex0_robid,
    input  exe_pkg::t_paddr     ex0_pc,
    input  exe_pkg::t_reg_data  ex0_src1_val,
    input  exe_pkg::t_reg_data  ex0_src2_reg_val,

    output logic                br_mispred_valid,
    output exe_pkg::t_rob_id    br_mispred_robid,
    output exe_pkg::t_paddr     br_mispred_target,

    output logic                wb_en,
    output exe_pkg::t_prf_id    wb_pdst,
    output exe_pkg::t_reg_data  wb_data,

    output logic                rob_valid,
    output exe_pkg::t_rob_id    rob_robid,
    output logic                rob_mispred
);

    exe_pkg::t_reg_data src2_val;
    exe_pkg::t_reg_data alu_result;
    exe_pkg::t_reg_data result_ex0;
    logic               alu_resvld;
    logic               br_resvld;

    logic               ex1_valid;
    logic               ex1_mispred;
    exe_pkg::t_optype   ex1_dst_type;
    exe_pkg::t_prf_id   ex1_pdst;
    exe_pkg::t_rob_id   ex1_robid;
    exe_pkg::t_reg_data ex1_result;

    always_comb begin
        case (ex0_src2_type)
            exe_pkg::OP_REG: src2_val = ex0_src2_reg_val;
            exe_pkg::OP_IMM: src2_val = ex0_imm;
            default:         src2_val = '0;
        endcase
    end

    int_alu i_int_alu (
        .uop    (ex0_uop),
        .valid  (ex0_valid),
        .src1   (ex0_src1_val),
        .src2   (src2_val),
        .resvld (alu_resvld),
        .result (alu_result)
    );

    // Compares use both register values, imm only feeds the target
    branch_unit i_branch_unit (
        .valid          (ex0_valid),
        .uop            (ex0_uop),
        .src1           (ex0_src1_val),
        .src2           (ex0_src2_reg_val),
        .pc             (ex0_pc),
        .imm            (ex0_imm),
        .robid          (ex0_robid),
        .resvld         (br_resvld),
        .mispred_valid  (br_mispred_valid),
        .mispred_robid  (br_mispred_robid),
        .mispred_target (br_mispred_target)
    );

    assign result_ex0 = alu_resvld ? alu_result : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex1_valid   <= 1'b0;
            ex1_mispred <= 1'b0;
        end else begin
            ex1_valid   <= ex0_valid & ~nuke;
            ex1_mispred <= br_mispred_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex1_dst_type <= ex0_dst_type;
        ex1_pdst     <= ex0_pdst;
        ex1_robid    <= ex0_robid;
        ex1_result   <= result_ex0;
    end

    assign wb_en       = ex1_valid && (ex1_dst_type == exe_pkg::OP_REG);
    assign wb_pdst     = ex1_pdst;
    assign wb_data     = ex1_result;
    assign rob_valid   = ex1_valid;
    assign rob_robid   = ex1_robid;
    assign rob_mispred = ex1_mispred;

    // Each valid micro-op is claimed by exactly one execution unit
    a_result_onehot: assert property (
        @(posedge clk) disable iff (reset)
        ex0_valid |-> $onehot({alu_resvld, br_resvld})
    ) else $error("exe result valid not one-hot for uop %0h", ex0_uop);

endmodule

`default_nettype wire

// ==== hw/exe_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_core #(
    parameter int NUM_PREGS = 64
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                nuke,

    input  logic                iss_valid,
    input  exe_pkg::t_uop       iss_uop,
    input  exe_pkg::t_prf_id    iss_src1,
    input  exe_pkg::t_prf_id    iss_src2,
    input  exe_pkg::t_optype    iss_src2_type,
    input  exe_pkg::t_reg_data  iss_imm,
    input  exe_pkg::t_prf_id    iss_pdst,
    input  exe_pkg::t_optype    iss_dst_type,
    input  exe_pkg::t_rob_id    iss_robid,
    input  exe_pkg::t_paddr     iss_pc,

    output logic                br_mispred_valid,
    output exe_pkg::t_rob_id    br_mispred_robid,
    output exe_pkg::t_paddr     br_mispred_target,

    output logic                wb_en,
    output exe_pkg::t_prf_id    wb_pdst,
    output exe_pkg::t_reg_data  wb_data,

    output logic                rob_valid,
    output exe_pkg::t_rob_id    rob_robid,
    output logic                rob_mispred
);

    exe_pkg::t_reg_data rd_data1;
    exe_pkg::t_reg_data rd_data2;

    logic               ex0_valid;
    exe_pkg::t_uop      ex0_uop;
    exe_pkg::t_optype   ex0_src2_type;
    exe_pkg::t_reg_data ex0_imm;
    exe_pkg::t_prf_id   ex0_pdst;
    exe_pkg::t_optype   ex0_dst_type;
    exe_pkg::t_rob_id   ex0_robid;
    exe_pkg::t_paddr    ex0_pc;
    exe_pkg::t_reg_data ex0_src1_val;
    exe_pkg::t_reg_data ex0_src2_reg_val;

    // Read ports addressed straight from issue
    int_prf #(
        .NUM_PREGS (NUM_PREGS)
    ) i_int_prf (
        .clk      (clk),
        .reset    (reset),
        .rd_addr1 (iss_src1),
        .rd_addr2 (iss_src2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr_en    (wb_en),
        .wr_addr  (wb_pdst),
        .wr_data  (wb_data)
    );

    reg_read i_reg_read (
        .clk              (clk),
        .reset            (reset),
        .nuke             (nuke),
        .iss_valid        (iss_valid),
        .iss_uop          (iss_uop),
        .iss_src1         (iss_src1),
        .iss_src2         (iss_src2),
        .iss_src2_type    (iss_src2_type),
        .iss_imm          (iss_imm),
        .iss_pdst         (iss_pdst),
        .iss_dst_type     (iss_dst_type),
        .iss_robid        (iss_robid),
        .iss_pc           (iss_pc),
        .rd_data1         (rd_data1),
        .rd_data2         (rd_data2),
        .wb_en            (wb_en),
        .wb_pdst          (wb_pdst),
        .wb_data          (wb_data),
        .ex0_valid        (ex0_valid),
        .ex0_uop          (ex0_uop),
        .ex0_src2_type    (ex0_src2_type),
        .ex0_imm          (ex0_imm),
        .ex0_pdst         (ex0_pdst),
        .ex0_dst_type     (ex0_dst_type),
        .ex0_robid        (ex0_robid),
        .ex0_pc           (ex0_pc),
        .ex0_src1_val     (ex0_src1_val),
        .ex0_src2_reg_val (ex0_src2_reg_val)
    );

    exe i_exe (
        .clk               (clk),
        .reset             (reset),
        .nuke              (nuke),
        .ex0_valid         (ex0_valid),
        .ex0_uop           (ex0_uop),
        .ex0_src2_type     (ex0_src2_type),
        .ex0_imm           (ex0_imm),
        .ex0_pdst          (ex0_pdst),
        .ex0_dst_type      (ex0_dst_type),
        .ex0_robid         (ex0_robid),
        .ex0_pc            (ex0_pc),
        .ex0_src1_val      (ex0_src1_val),
        .ex0_src2_reg_val  (ex0_src2_reg_val),
        .br_mispred_valid  (br_mispred_valid),
        .br_mispred_robid  (br_mispred_robid),
        .br_mispred_target (br_mispred_target),
        .wb_en             (wb_en),
        .wb_pdst           (wb_pdst),
        .wb_data           (wb_data),
        .rob_valid         (rob_valid),
        .rob_robid         (rob_robid),
        .rob_mispred       (rob_mispred)
    );

endmodule

`default_nettype wire

// ==== tb/exe_checks.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_checks (
    input  logic                clk,
    input  logic                reset,

    input  logic                br_mispred_valid,
    input  exe_pkg::t_rob_id    br_mispred_robid,
    input  exe_pkg::t_paddr     br_mispred_target,
    input  logic                wb_en,
    input  exe_pkg::t_prf_id    wb_pdst,
    input  exe_pkg::t_reg_data  wb_data,
    input  logic                rob_valid,
    input  exe_pkg::t_rob_id    rob_robid,
    input  logic                rob_mispred,

    input  logic                exp_mp_valid,
    input  exe_pkg::t_rob_id    exp_mp_robid,
    input  exe_pkg::t_paddr     exp_mp_target,
    input  logic                exp_wb_en,
    input  exe_pkg::t_prf_id    exp_wb_pdst,
    input  exe_pkg::t_reg_data  exp_wb_data,
    input  logic                exp_rob_valid,
    input  exe_pkg::t_rob_id    exp_rob_robid,
    input  logic                exp_rob_mispred,

    output logic                failed
);

    initial failed = 1'b0;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("Mismatch %s: got %h, expected %h", name, got, expected);
        failed = 1'b1;
    endtask

    // First cycle out of reset
    a_idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !wb_en && !rob_valid && !br_mispred_valid)
        else report_mismatch("wb_en/rob_valid/br_mispred_valid after reset",
            {$sampled(wb_en), $sampled(rob_valid), $sampled(br_mispred_valid)}, 0);

    a_mp_valid: assert property (@(posedge clk) disable iff (reset)
        br_mispred_valid == exp_mp_valid)
        else report_mismatch("br_mispred_valid", $sampled(br_mispred_valid), $sampled(exp_mp_valid));

    a_mp_robid: assert property (@(posedge clk) disable iff (reset)
        exp_mp_valid |-> br_mispred_robid == exp_mp_robid)
        else report_mismatch("br_mispred_robid", $sampled(br_mispred_robid), $sampled(exp_mp_robid));

    a_mp_target: assert property (@(posedge clk) disable iff (reset)
        exp_mp_valid |-> br_mispred_target == exp_mp_target)
        else report_mismatch("br_mispred_target", $sampled(br_mispred_target),
            $sampled(exp_mp_target));

    a_wb_en: assert property (@(posedge clk) disable iff (reset)
        wb_en == exp_wb_en)
        else report_mismatch("wb_en", $sampled(wb_en), $sampled(exp_wb_en));

    a_wb_pdst: assert property (@(posedge clk) disable iff (reset)
        exp_wb_en |-> wb_pdst == exp_wb_pdst)
        else report_mismatch("wb_pdst", $sampled(wb_pdst), $sampled(exp_wb_pdst));

    a_wb_data: assert property (@(posedge clk) disable iff (reset)
        exp_wb_en |-> wb_data == exp_wb_data)
        else report_mismatch("wb_data", $sampled(wb_data), $sampled(exp_wb_data));

    a_rob_valid: assert property (@(posedge clk) disable iff (reset)
        rob_valid == exp_rob_valid)
        else report_mismatch("rob_valid", $sampled(rob_valid), $sampled(exp_rob_valid));

    a_rob_robid: assert property (@(posedge clk) disable iff (reset)
        exp_rob_valid |-> rob_robid == exp_rob_robid)
        else report_mismatch("rob_robid", $sampled(rob_robid), $sampled(exp_rob_robid));

    a_rob_mispred: assert property (@(posedge clk) disable iff (reset)
        exp_rob_valid |-> rob_mispred == exp_rob_mispred)
        else report_mismatch("rob_mispred", $sampled(rob_mispred), $sampled(exp_rob_mispred));

endmodule

`default_nettype wire

// ==== tb/tb_exe_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exe_core;

    localparam int NUM_PREGS    = 64;
    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;
    localparam int RESET_CYCLES = 5;
    localparam int RAND_OPS     = 300;
    localparam int CHAINS       = 8;
    localparam int CHAIN_LEN    = 12;
    localparam int BURSTS       = 6;
    localparam int BURST_LEN    = 10;
    localparam int NUKE_ROUNDS  = 24;
    // Up to three cycles per random op and four per nuke round
    localparam int CYCLE_BUDGET = RESET_CYCLES + NUM_PREGS / 2 + 3 * RAND_OPS
                                + CHAINS * CHAIN_LEN + BURSTS * BURST_LEN
                                + 4 * NUKE_ROUNDS + 10;

    typedef struct packed {
        logic               valid;
        logic               taken;
        logic               wb;
        exe_pkg::t_rob_id   robid;
        exe_pkg::t_paddr    target;
        exe_pkg::t_prf_id   pdst;
        exe_pkg::t_reg_data data;
    } t_expect;

    logic               clk;
    logic               reset;
    logic               nuke;
    logic               iss_valid;
    exe_pkg::t_uop      iss_uop;
    exe_pkg::t_prf_id   iss_src1;
    exe_pkg::t_prf_id   iss_src2;
    exe_pkg::t_optype   iss_src2_type;
    exe_pkg::t_reg_data iss_imm;
    exe_pkg::t_prf_id   iss_pdst;
    exe_pkg::t_optype   iss_dst_type;
    exe_pkg::t_rob_id   iss_robid;
    exe_pkg::t_paddr    iss_pc;

    logic               br_mispred_valid;
    exe_pkg::t_rob_id   br_mispred_robid;
    exe_pkg::t_paddr    br_mispred_target;
    logic               wb_en;
    exe_pkg::t_prf_id   wb_pdst;
    exe_pkg::t_reg_data wb_data;
    logic               rob_valid;
    exe_pkg::t_rob_id   rob_robid;
    logic               rob_mispred;
    logic               check_failed;

    // Reference register state and the undo record for a nuked micro-op
    exe_pkg::t_reg_data shadow [NUM_PREGS];
    exe_pkg::t_rob_id   rob_ctr;
    logic               last_wrote;
    exe_pkg::t_prf_id   last_pdst;
    exe_pkg::t_reg_data last_old;

    // Expected record at issue and as seen in EX0 and EX1
    t_expect nxt;
    t_expect e0;
    t_expect e1;

    exe_core #(
        .NUM_PREGS (NUM_PREGS)
    ) i_exe_core (
        .clk               (clk),
        .reset             (reset),
        .nuke              (nuke),
        .iss_valid         (iss_valid),
        .iss_uop           (iss_uop),
        .iss_src1          (iss_src1),
        .iss_src2          (iss_src2),
        .iss_src2_type     (iss_src2_type),
        .iss_imm           (iss_imm),
        .iss_pdst          (iss_pdst),
        .iss_dst_type      (iss_dst_type),
        .iss_robid         (iss_robid),
        .iss_pc            (iss_pc),
        .br_mispred_valid  (br_mispred_valid),
        .br_mispred_robid  (br_mispred_robid),
        .br_mispred_target (br_mispred_target),
        .wb_en             (wb_en),
        .wb_pdst           (wb_pdst),
        .wb_data           (wb_data),
        .rob_valid         (rob_valid),
        .rob_robid         (rob_robid),
        .rob_mispred       (rob_mispred)
    );

    exe_checks i_exe_checks (
        .clk               (clk),
        .reset             (reset),
        .br_mispred_valid  (br_mispred_valid),
        .br_mispred_robid  (br_mispred_robid),
        .br_mispred_target (br_mispred_target),
        .wb_en             (wb_en),
        .wb_pdst           (wb_pdst),
        .wb_data           (wb_data),
        .rob_valid         (rob_valid),
        .rob_robid         (rob_robid),
        .rob_mispred       (rob_mispred),
        .exp_mp_valid      (e0.valid && e0.taken),
        .exp_mp_robid      (e0.robid),
        .exp_mp_target     (e0.target),
        .exp_wb_en         (e1.valid && e1.wb),
        .exp_wb_pdst       (e1.pdst),
        .exp_wb_data       (e1.data),
        .exp_rob_valid     (e1.valid),
        .exp_rob_robid     (e1.robid),
        .exp_rob_mispred   (e1.taken),
        .failed            (check_failed)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Two-deep expected queue
    always @(posedge clk) begin
        if (reset) begin
            e0 <= '0;
            e1 <= '0;
        end else begin
            e0 <= nxt;
            e1 <= e0;
            // Nuke drops the entry leaving EX0
            if (nuke) begin
                e1.valid <= 1'b0;
            end
        end
    end

    function automatic logic signed_less(input exe_pkg::t_reg_data a,
                                         input exe_pkg::t_reg_data b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic exe_pkg::t_reg_data alu_ref(input exe_pkg::t_uop uop,
                                                   input exe_pkg::t_reg_data a,
                                                   input exe_pkg::t_reg_data b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (uop)
            exe_pkg::U_ADD:  return a + b;
            exe_pkg::U_SUB:  return a + ~b + 32'd1;
            exe_pkg::U_AND:  return a & b;
            exe_pkg::U_OR:   return a | b;
            exe_pkg::U_XOR:  return a ^ b;
            exe_pkg::U_SLL:  return a << b[4:0];
            exe_pkg::U_SRL:  return a >> b[4:0];
            exe_pkg::U_SRA:  return ext[31:0];
            exe_pkg::U_SLT:  return {31'd0, signed_less(a, b)};
            exe_pkg::U_SLTU: return {31'd0, a < b};
            default:         return '0;
        endcase
    endfunction

    function automatic logic branch_ref(input exe_pkg::t_uop uop,
                                        input exe_pkg::t_reg_data a,
                                        input exe_pkg::t_reg_data b);
        case (uop)
            exe_pkg::U_BEQ:  return a == b;
            exe_pkg::U_BNE:  return a != b;
            exe_pkg::U_BLT:  return signed_less(a, b);
            exe_pkg::U_BGE:  return !signed_less(a, b);
            exe_pkg::U_BLTU: return a < b;
            exe_pkg::U_BGEU: return a >= b;
            default:         return 1'b0;
        endcase
    endfunction

    task automatic drive_cycle(input logic valid, input exe_pkg::t_uop uop,
                               input exe_pkg::t_prf_id s1, input exe_pkg::t_prf_id s2,
                               input exe_pkg::t_optype s2t, input exe_pkg::t_reg_data imm,
                               input exe_pkg::t_prf_id pd, input exe_pkg::t_optype dt,
                               input logic kill);
        exe_pkg::t_reg_data b;
        exe_pkg::t_paddr    pc;
        logic               is_br;
        @(posedge clk);
        #DRIVE_DLY;
        pc    = $urandom & 32'hffff_fffc;
        is_br = (uop >= exe_pkg::U_BEQ);
        if (s2t == exe_pkg::OP_REG) begin
            b = shadow[s2];
        end else if (s2t == exe_pkg::OP_IMM) begin
            b = imm;
        end else begin
            b = '0;
        end
        iss_valid     = valid;
        iss_uop       = uop;
        iss_src1      = s1;
        iss_src2      = s2;
        iss_src2_type = s2t;
        iss_imm       = imm;
        iss_pdst      = pd;
        iss_dst_type  = dt;
        iss_robid     = rob_ctr;
        iss_pc        = pc;
        nuke          = kill;
        nxt.valid  = valid && !kill;
        nxt.taken  = is_br && branch_ref(uop, shadow[s1], shadow[s2]);
        nxt.wb     = (dt == exe_pkg::OP_REG);
        nxt.robid  = rob_ctr;
        nxt.target = pc + imm;
        nxt.pdst   = pd;
        nxt.data   = is_br ? '0 : alu_ref(uop, shadow[s1], b);
        // Nuke also kills the micro-op issued one cycle earlier
        if (kill && last_wrote) begin
            shadow[last_pdst] = last_old;
        end
        last_wrote = nxt.valid && nxt.wb;
        if (last_wrote) begin
            last_pdst  = pd;
            last_old   = shadow[pd];
            shadow[pd] = nxt.data;
        end
        if (valid) begin
            rob_ctr++;
        end
    endtask

    task automatic idle_cycle(input logic kill);
        drive_cycle(1'b0, exe_pkg::U_ADD, 0, 0, exe_pkg::OP_NONE, '0, 0,
                    exe_pkg::OP_NONE, kill);
    endtask

    task automatic issue_random(input int span, input logic kill);
        exe_pkg::t_uop    uop;
        exe_pkg::t_optype dt;
        uop = exe_pkg::t_uop'($urandom_range(15, 0));
        dt  = (uop >= exe_pkg::U_BEQ || $urandom_range(3, 0) == 0) ?
              exe_pkg::OP_NONE : exe_pkg::OP_REG;
        drive_cycle(1'b1, uop, $urandom_range(span - 1, 0), $urandom_range(span - 1, 0),
                    exe_pkg::t_optype'($urandom_range(2, 0)), $urandom,
                    $urandom_range(span - 1, 0), dt, kill);
    endtask

    initial begin
        wait (check_failed === 1'b1);
        $display("Simulation failed");
        $fatal(1, "A DUT output check failed");
    end

    initial begin
        #((CYCLE_BUDGET + 100) * CLK_PERIOD);
        $display("Simulation failed");
        $fatal(1, "Run did not finish within %0d cycles", CYCLE_BUDGET + 100);
    end

    initial begin
        exe_pkg::t_prf_id pd;
        exe_pkg::t_prf_id prev1;
        exe_pkg::t_prf_id prev2;
        exe_pkg::t_prf_id s1;
        exe_pkg::t_prf_id s2;
        void'($urandom(71));
        reset         = 1'b1;
        nuke          = 1'b0;
        iss_valid     = 1'b0;
        iss_uop       = exe_pkg::U_ADD;
        iss_src1      = '0;
        iss_src2      = '0;
        iss_src2_type = exe_pkg::OP_NONE;
        iss_imm       = '0;
        iss_pdst      = '0;
        iss_dst_type  = exe_pkg::OP_NONE;
        iss_robid     = '0;
        iss_pc        = '0;
        nxt           = '0;
        rob_ctr       = '0;
        last_wrote    = 1'b0;
        last_pdst     = '0;
        last_old      = '0;
        pd            = '0;
        prev1         = '0;
        for (int i = 0; i < NUM_PREGS; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        // Every register must still read zero
        for (int i = 0; i < NUM_PREGS; i += 2) begin
            drive_cycle(1'b1, exe_pkg::U_OR, i, i + 1, exe_pkg::OP_REG, $urandom, i,
                        exe_pkg::OP_REG, 1'b0);
        end

        for (int n = 0; n < RAND_OPS; n++) begin
            issue_random(NUM_PREGS, 1'b0);
            repeat ($urandom_range(2, 0)) idle_cycle(1'b0);
        end

        // Each link reads the two links before it
        for (int c = 0; c < CHAINS; c++) begin
            for (int k = 0; k < CHAIN_LEN; k++) begin
                prev2 = prev1;
                prev1 = pd;
                pd    = $urandom_range(NUM_PREGS - 1, 0);
                // Odd links swap the two sources between the read ports
                if (k % 2 == 0) begin
                    s1 = prev1;
                    s2 = prev2;
                end else begin
                    s1 = prev2;
                    s2 = prev1;
                end
                drive_cycle(1'b1, exe_pkg::t_uop'($urandom_range(9, 0)), s1, s2,
                            (k % 3 == 0) ? exe_pkg::OP_IMM : exe_pkg::OP_REG, $urandom,
                            pd, exe_pkg::OP_REG, 1'b0);
            end
        end

        for (int bu = 0; bu < BURSTS; bu++) begin
            for (int k = 0; k < BURST_LEN; k++) begin
                s1 = $urandom_range(NUM_PREGS - 1, 0);
                s2 = ($urandom_range(3, 0) == 0) ? s1 : $urandom_range(NUM_PREGS - 1, 0);
                drive_cycle(1'b1, exe_pkg::t_uop'($urandom_range(15, 10)), s1, s2,
                            exe_pkg::OP_REG, $urandom, 0, exe_pkg::OP_NONE, 1'b0);
            end
        end

        // Eight registers keep later micro-ops reading what nuked ones targeted
        for (int r = 0; r < NUKE_ROUNDS; r++) begin
            issue_random(8, 1'b0);
            issue_random(8, 1'b0);
            if (r % 2 == 0) begin
                issue_random(8, 1'b1);
            end else begin
                idle_cycle(1'b1);
            end
            issue_random(8, 1'b0);
        end

        repeat (4) idle_cycle(1'b0);
        @(posedge clk);
        if (check_failed) begin
            $display("Simulation failed");
            $fatal(1, "A DUT output check failed");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/exe_pkg.sv
hw/int_prf.sv
hw/reg_read.sv
hw/int_alu.sv
hw/branch_unit.sv
hw/exe.sv
hw/exe_core.sv
tb/exe_checks.sv
tb/tb_exe_core.sv
